/* rtl/ps2_spam_pkg.sv */
package ps2_spam_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// spam bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [23:0] spam_addr_t;
	typedef logic [31:0] spam_data_t;
	typedef logic [3:0]  spam_did_t;

	localparam spam_did_t  SPAM_DID_PS2  = 4'h2;
	localparam spam_data_t SPAM_RD_EMPTY = 32'hdeadbeef; // read of an empty fifo

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ps/2 framing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0] ps2_byte_t;
	typedef logic [3:0] ps2_bitcnt_t;

	// start, 8 data lsb first, odd parity, stop
	localparam int PS2_FRAME_BITS = 11;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

/* rtl/ps2_chan_if.sv */
`timescale 1ns/1ps

interface ps2_chan_if;
	import ps2_spam_pkg::*;

	logic      pop;     // decoder -> channel, one cycle
	logic      sel;     // decoder -> response, addressed channel
	logic      empty;
	ps2_byte_t rd_data; // fifo head before the pop

	modport decode (
		output pop,
		output sel,
		input  empty
	);

	modport chan (
		input  pop,
		output empty,
		output rd_data
	);

	modport resp (
		input  sel,
		input  empty,
		input  rd_data
	);

endinterface

/* rtl/ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx (
	input  logic                     cclk,
	input  logic                     cclk_rst_b,
	input  logic                     ps2clk,
	input  logic                     ps2data,
	output logic                     byte_valid,
	output ps2_spam_pkg::ps2_byte_t  byte_data
);
	import ps2_spam_pkg::*;

	logic        clk_s;
	logic        clk_q;
	logic        clk_1a;
	logic        dat_s;
	logic        dat_q;
	logic        fall;
	rx_state_t   state;
	ps2_bitcnt_t bitcnt;
	ps2_byte_t   key;
	logic        parity;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sync into cclk, data follows the same two flops
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			clk_s  <= 1'b1; // bus idles high
			clk_q  <= 1'b1;
			clk_1a <= 1'b1;
			dat_s  <= 1'b1;
			dat_q  <= 1'b1;
		end else begin
			clk_s  <= ps2clk;
			clk_q  <= clk_s;
			clk_1a <= clk_q;
			dat_s  <= ps2data;
			dat_q  <= dat_s;
		end
	end

	assign fall = clk_1a && !clk_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame fsm, bitcnt is the frame position of the next bit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			state  <= RX_IDLE;
			bitcnt <= '0;
		end else if (fall) begin
			unique case (state)
				RX_IDLE: begin
					if (!dat_q) begin // start bit
						state  <= RX_DATA;
						bitcnt <= 4'd1;
					end
				end
				RX_DATA: begin
					bitcnt <= bitcnt + 4'd1;
					if (bitcnt == 4'd8)
						state <= RX_PARITY;
				end
				RX_PARITY: begin
					bitcnt <= bitcnt + 4'd1;
					state  <= RX_STOP;
				end
				RX_STOP: begin
					bitcnt <= '0;
					state  <= RX_IDLE;
				end
				default: begin
					bitcnt <= '0;
					state  <= RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (fall && state == RX_DATA)
			key <= {dat_q, key[7:1]}; // lsb arrives first
		if (fall && state == RX_PARITY)
			parity <= dat_q;
	end

	// stop bit itself is not checked
	assign byte_valid = fall && (state == RX_STOP) &&
	                    (bitcnt == ps2_bitcnt_t'(PS2_FRAME_BITS - 1)) &&
	                    (^{key, parity});
	assign byte_data  = key;

endmodule

/* rtl/ps2_key_fifo.sv */
`timescale 1ns/1ps

module ps2_key_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                     cclk,
	input  logic                     cclk_rst_b,
	input  logic                     wr_en,
	input  ps2_spam_pkg::ps2_byte_t  wr_data,
	input  logic                     rd_en,
	output ps2_spam_pkg::ps2_byte_t  rd_data,
	output logic                     empty
);
	import ps2_spam_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	ps2_byte_t     mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          do_wr;
	logic          do_rd;

	// wraps at DEPTH, so any depth works
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CW'(DEPTH));
	assign do_wr   = wr_en && !full; // new byte lost when full
	assign do_rd   = rd_en && !empty;
	assign rd_data = mem[rd_ptr];   // head always visible

	always_ff @(posedge cclk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_next(rd_ptr);
			unique case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* rtl/ps2_channel.sv */
`timescale 1ns/1ps

module ps2_channel #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       cclk,
	input  logic       cclk_rst_b,
	input  logic       ps2clk,
	input  logic       ps2data,
	ps2_chan_if.chan   ch
);
	import ps2_spam_pkg::*;

	logic      rx_valid;
	ps2_byte_t rx_byte;

	ps2_frame_rx u_rx (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.ps2clk     (ps2clk),
		.ps2data    (ps2data),
		.byte_valid (rx_valid),
		.byte_data  (rx_byte)
	);

	// pop only arrives when not empty, decoder guarantees it
	ps2_key_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.wr_en      (rx_valid),
		.wr_data    (rx_byte),
		.rd_en      (ch.pop),
		.rd_data    (ch.rd_data),
		.empty      (ch.empty)
	);

endmodule

/* rtl/spam_rd_decode.sv */
`timescale 1ns/1ps

module spam_rd_decode #(
	parameter int                       NUM_PORTS     = 2,
	parameter ps2_spam_pkg::spam_addr_t SPAM_ADDRPFX  = 24'h0a0000,
	parameter ps2_spam_pkg::spam_addr_t SPAM_ADDRMASK = 24'hffffff
) (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	input  logic                      spamo_valid,
	input  logic                      spamo_r_nw,
	input  ps2_spam_pkg::spam_did_t   spamo_did,
	input  ps2_spam_pkg::spam_addr_t  spamo_addr,
	ps2_chan_if.decode                ch [NUM_PORTS]
);
	import ps2_spam_pkg::*;

	localparam int         CH_BITS  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	localparam spam_addr_t CH_FIELD = spam_addr_t'((1 << CH_BITS) - 1);

	logic [CH_BITS-1:0] ch_idx;
	logic               did_ok;
	logic               pfx_ok;
	logic               in_range;
	logic               rd_hit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hit rule, writes never hit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign ch_idx   = spamo_addr[CH_BITS-1:0];
	assign did_ok   = (spamo_did == SPAM_DID_PS2);
	// channel bits are excluded from the prefix compare
	assign pfx_ok   = ((spamo_addr & SPAM_ADDRMASK & ~CH_FIELD) ==
	                   (SPAM_ADDRPFX & ~CH_FIELD));
	assign in_range = (int'(ch_idx) < NUM_PORTS);
	assign rd_hit   = spamo_valid && spamo_r_nw && did_ok && pfx_ok && in_range;

	// one-hot select, pop only a channel with data
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_sel
		assign ch[i].sel = rd_hit && (ch_idx == CH_BITS'(i));
		assign ch[i].pop = ch[i].sel && !ch[i].empty;
	end

endmodule

/* rtl/spam_rd_resp.sv */
`timescale 1ns/1ps

module spam_rd_resp #(
	parameter int NUM_PORTS = 2
) (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	ps2_chan_if.resp                  ch [NUM_PORTS],
	output logic                      spami_busy_b,
	output ps2_spam_pkg::spam_data_t  spami_data
);
	import ps2_spam_pkg::*;

	logic [NUM_PORTS-1:0] sel_v;
	logic [NUM_PORTS-1:0] empty_v;
	ps2_byte_t            head_v [NUM_PORTS];
	logic                 hit_0a;
	logic                 popped_0a;
	ps2_byte_t            byte_0a;
	logic                 hit_1a;
	logic                 popped_1a;
	ps2_byte_t            byte_1a;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_gather
		assign sel_v[i]   = ch[i].sel;
		assign empty_v[i] = ch[i].empty;
		assign head_v[i]  = ch[i].rd_data;
	end

	assign hit_0a    = |sel_v;
	assign popped_0a = |(sel_v & ~empty_v);

	always_comb begin
		byte_0a = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (sel_v[i])
				byte_0a = head_v[i]; // sel is one-hot
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			hit_1a    <= 1'b0;
			popped_1a <= 1'b0;
		end else begin
			hit_1a    <= hit_0a;
			popped_1a <= popped_0a;
		end
	end

	always_ff @(posedge cclk) begin
		byte_1a <= byte_0a;
	end

	assign spami_busy_b = hit_1a;

	always_comb begin
		if (!hit_1a)
			spami_data = '0;
		else if (popped_1a)
			spami_data = spam_data_t'(byte_1a); // zero-extended
		else
			spami_data = SPAM_RD_EMPTY;
	end

endmodule

/* rtl/ps2_spam_top.sv */
`timescale 1ns/1ps

module ps2_spam_top #(
	parameter int                       NUM_PORTS     = 2,
	parameter int                       FIFO_DEPTH    = 16,
	parameter ps2_spam_pkg::spam_addr_t SPAM_ADDRPFX  = 24'h0a0000,
	parameter ps2_spam_pkg::spam_addr_t SPAM_ADDRMASK = 24'hffffff
) (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	input  logic [NUM_PORTS-1:0]      ps2clk,
	input  logic [NUM_PORTS-1:0]      ps2data,
	input  logic                      spamo_valid,
	input  logic                      spamo_r_nw,
	input  ps2_spam_pkg::spam_did_t   spamo_did,
	input  ps2_spam_pkg::spam_addr_t  spamo_addr,
	input  ps2_spam_pkg::spam_data_t  spamo_data, // no writes, left open
	output logic                      spami_busy_b,
	output ps2_spam_pkg::spam_data_t  spami_data
);

	ps2_chan_if ch_if [NUM_PORTS] ();

	spam_rd_decode #(
		.NUM_PORTS     (NUM_PORTS),
		.SPAM_ADDRPFX  (SPAM_ADDRPFX),
		.SPAM_ADDRMASK (SPAM_ADDRMASK)
	) u_decode (
		.cclk        (cclk),
		.cclk_rst_b  (cclk_rst_b),
		.spamo_valid (spamo_valid),
		.spamo_r_nw  (spamo_r_nw),
		.spamo_did   (spamo_did),
		.spamo_addr  (spamo_addr),
		.ch          (ch_if)
	);

	// one receiver and fifo per ps/2 port
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		ps2_channel #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) u_chan (
			.cclk       (cclk),
			.cclk_rst_b (cclk_rst_b),
			.ps2clk     (ps2clk[i]),
			.ps2data    (ps2data[i]),
			.ch         (ch_if[i])
		);
	end

	spam_rd_resp #(
		.NUM_PORTS (NUM_PORTS)
	) u_resp (
		.cclk         (cclk),
		.cclk_rst_b   (cclk_rst_b),
		.ch           (ch_if),
		.spami_busy_b (spami_busy_b),
		.spami_data   (spami_data)
	);

endmodule

/* verification/ps2_spam_checker.sv */
`timescale 1ns/1ps

module ps2_spam_checker #(
	parameter int          NUM_PORTS  = 2,
	parameter int          FIFO_DEPTH = 4,
	parameter logic [23:0] ADDR_PFX   = 24'h0a0000,
	parameter logic [23:0] ADDR_MASK  = 24'hffffff
) (
	input  logic        cclk,
	input  logic        cclk_rst_b,
	input  logic        spamo_valid,
	input  logic        spamo_r_nw,
	input  logic [3:0]  spamo_did,
	input  logic [23:0] spamo_addr,
	input  logic        spami_busy_b,
	input  logic [31:0] spami_data,
	input  logic        sent_valid, // one pulse per frame from the driver
	input  int          sent_port,
	input  logic [7:0]  sent_byte,
	input  logic        sent_ok,
	input  int          test_id,
	output int          checks,
	output int          errors
);

	localparam int CH_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [7:0]  q0 [$]; // model fifos
	logic [7:0]  q1 [$];
	logic        pend;
	logic        exp_busy;
	logic [31:0] exp_data;
	int          pop_port;

	// hit rule and next-cycle response, pop_port is -1 when nothing pops
	function automatic void ref_response(input logic r_nw, input logic [3:0] did,
			input logic [23:0] addr, output logic busy, output logic [31:0] data,
			output int port);
		logic [23:0] chf;
		int          idx;
		chf  = (24'd1 << CH_BITS) - 24'd1;
		idx  = int'(addr & chf);
		busy = r_nw && (did == 4'h2) && ((addr & ADDR_MASK & ~chf) == (ADDR_PFX & ~chf)) &&
		       (idx < NUM_PORTS);
		data = busy ? 32'hdeadbeef : 32'h0;
		port = -1;
		if (busy && idx == 0 && q0.size() > 0) begin
			data = {24'h0, q0[0]};
			port = 0;
		end
		if (busy && idx == 1 && q1.size() > 0) begin
			data = {24'h0, q1[0]};
			port = 1;
		end
	endfunction

	function automatic string test_label(input int id);
		case (id)
			1: return "in_order";
			2: return "bad_parity";
			3: return "empty_read";
			4: return "no_hit";
			5: return "two_ports";
			6: return "overflow";
			default: return "startup";
		endcase
	endfunction

	initial begin
		checks = 0;
		errors = 0;
		pend   = 1'b0;
	end

	// negedge, inputs and registered outputs are both settled here
	always @(negedge cclk) begin
		if (!cclk_rst_b) begin
			pend = 1'b0;
		end else begin
			if (pend) begin
				checks++;
				if (spami_busy_b !== exp_busy || spami_data !== exp_data) begin
					errors++;
					$display("Error %s: expected busy_b %b data %h, actual busy_b %b data %h",
						test_label(test_id), exp_busy, exp_data, spami_busy_b, spami_data);
				end
			end else if (spami_busy_b !== 1'b0 || spami_data !== 32'h0) begin
				errors++;
				$display("%s: response seen with no request in the cycle before (data %h)",
					test_label(test_id), spami_data);
			end
			if (sent_valid && sent_ok && sent_port == 0 && q0.size() < FIFO_DEPTH)
				q0.push_back(sent_byte);
			if (sent_valid && sent_ok && sent_port == 1 && q1.size() < FIFO_DEPTH)
				q1.push_back(sent_byte);
			pend = spamo_valid;
			if (spamo_valid) begin
				ref_response(spamo_r_nw, spamo_did, spamo_addr, exp_busy, exp_data, pop_port);
				if (pop_port == 0)
					void'(q0.pop_front());
				if (pop_port == 1)
					void'(q1.pop_front());
			end
		end
	end

endmodule

/* verification/tb_ps2_spam.sv */
`timescale 1ns/1ps

module tb_ps2_spam;

	localparam int          NUM_PORTS  = 2;
	localparam int          FIFO_DEPTH = 4;
	localparam logic [23:0] ADDR_PFX   = 24'h0a0000;
	localparam logic [23:0] ADDR_MASK  = 24'hffffff;
	localparam int          HALF       = 8;  // ps2 half period in cclk
	localparam int          NUM_FRAMES = 20;
	localparam int          NUM_REQS   = 24;
	localparam int          LIMIT      = 2 * (NUM_FRAMES * 176 + NUM_REQS * 4);

	logic                 cclk;
	logic                 cclk_rst_b;
	logic [NUM_PORTS-1:0] ps2clk;
	logic [NUM_PORTS-1:0] ps2data;
	logic                 spamo_valid;
	logic                 spamo_r_nw;
	logic [3:0]           spamo_did;
	logic [23:0]          spamo_addr;
	logic [31:0]          spamo_data;
	logic                 spami_busy_b;
	logic [31:0]          spami_data;
	logic                 sent_valid;
	int                   sent_port;
	logic [7:0]           sent_byte;
	logic                 sent_ok;
	int                   test_id;
	int                   checks;
	int                   errors;
	int                   reqs;
	int                   cycles;
	logic [31:0]          rng;
	logic [7:0]           b;

	ps2_spam_top #(
		.NUM_PORTS     (NUM_PORTS),
		.FIFO_DEPTH    (FIFO_DEPTH),
		.SPAM_ADDRPFX  (ADDR_PFX),
		.SPAM_ADDRMASK (ADDR_MASK)
	) u_dut (.*);

	ps2_spam_checker #(
		.NUM_PORTS  (NUM_PORTS),
		.FIFO_DEPTH (FIFO_DEPTH),
		.ADDR_PFX   (ADDR_PFX),
		.ADDR_MASK  (ADDR_MASK)
	) u_chk (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic step();
		@(posedge cclk);
		#2;
	endtask

	task automatic rand_byte(output logic [7:0] v);
		rng = xorshift32(rng);
		v   = rng[7:0];
	endtask

	// start, data lsb first, parity, stop; 176 cclk per frame
	task automatic send_frame(input int port, input logic [7:0] data, input logic par_ok);
		logic [10:0] bits;
		bits = {1'b1, (par_ok ? ~^data : ^data), data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2data[port] = bits[i];
			repeat (HALF) step();
			ps2clk[port] = 1'b0;
			repeat (HALF) step();
			ps2clk[port] = 1'b1;
		end
		repeat (4) step();
		sent_valid = 1'b1; // tell the checker
		sent_port  = port;
		sent_byte  = data;
		sent_ok    = par_ok;
		step();
		sent_valid = 1'b0;
	endtask

	task automatic bus_req(input logic [3:0] did, input logic [23:0] addr, input logic r_nw);
		step();
		spamo_valid = 1'b1;
		spamo_r_nw  = r_nw;
		spamo_did   = did;
		spamo_addr  = addr;
		spamo_data  = r_nw ? 32'h0 : rng;
		reqs++;
	endtask

	task automatic read_port(input int port);
		bus_req(4'h2, ADDR_PFX | 24'(port), 1'b1);
	endtask

	task automatic bus_idle();
		step();
		spamo_valid = 1'b0;
		spamo_r_nw  = 1'b0;
		spamo_did   = '0;
		spamo_addr  = '0;
		spamo_data  = '0;
		repeat (2) step(); // last response still in flight
	endtask

	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk;
	end

	initial begin
		cclk_rst_b  = 1'b0;
		ps2clk      = '1;
		ps2data     = '1;
		spamo_valid = 1'b0;
		spamo_r_nw  = 1'b0;
		spamo_did   = '0;
		spamo_addr  = '0;
		spamo_data  = '0;
		sent_valid  = 1'b0;
		sent_port   = 0;
		sent_byte   = '0;
		sent_ok     = 1'b0;
		test_id     = 0;
		reqs        = 0;
		rng         = 32'ha873bef3;
		repeat (5) @(posedge cclk);
		#2;
		cclk_rst_b = 1'b1;
		step();

		test_id = 1;
		repeat (3) begin
			rand_byte(b);
			send_frame(0, b, 1'b1);
		end
		repeat (3) read_port(0);
		bus_idle();

		test_id = 2;
		rand_byte(b);
		send_frame(0, b, 1'b0);
		rand_byte(b);
		send_frame(0, b, 1'b1);
		repeat (2) read_port(0); // good byte, then empty
		bus_idle();

		test_id = 3;
		read_port(1);
		bus_idle();

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// misses must leave the queued byte alone
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		test_id = 4;
		rand_byte(b);
		send_frame(0, b, 1'b1);
		bus_req(4'h3, ADDR_PFX, 1'b1);
		bus_req(4'h2, ADDR_PFX, 1'b0);
		bus_req(4'h2, ADDR_PFX ^ 24'h010000, 1'b1);
		bus_req(4'h2, ADDR_PFX | 24'(NUM_PORTS), 1'b1);
		read_port(0);
		bus_idle();

		test_id = 5;
		repeat (4) begin
			rand_byte(b);
			send_frame(0, b, 1'b1);
			rand_byte(b);
			send_frame(1, b, 1'b1);
		end
		repeat (4) begin
			read_port(1);
			read_port(0);
		end
		bus_idle();

		test_id = 6;
		repeat (6) begin
			rand_byte(b);
			send_frame(1, b, 1'b1);
		end
		repeat (5) read_port(1); // fifth finds it empty
		bus_idle();

		if (checks != reqs)
			$display("only %0d of %0d bus requests had their response checked", checks, reqs);
		$display("requests %0d, checks %0d, errors %0d", reqs, checks, errors);
		if (errors == 0 && checks == reqs) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge cclk);
			cycles++;
		end
		$display("run did not complete within %0d cycles", LIMIT);
		$display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
rtl/ps2_spam_pkg.sv
rtl/ps2_chan_if.sv
rtl/ps2_frame_rx.sv
rtl/ps2_key_fifo.sv
rtl/ps2_channel.sv
rtl/spam_rd_decode.sv
rtl/spam_rd_resp.sv
rtl/ps2_spam_top.sv
verification/ps2_spam_checker.sv
verification/tb_ps2_spam.sv
